/* all.f */
design/conv_pkg.sv
design/conv_ctrl.sv
design/window_loader.sv
design/weight_decoder.sv
design/mac_array.sv
design/requant_writer.sv
design/conv_top.sv
tests/tb_clock.sv
tests/conv_tb.sv

/* Bender.yml */
package:
  name: conv_engine

sources:
  - design/conv_pkg.sv
  - design/conv_ctrl.sv
  - design/window_loader.sv
  - design/weight_decoder.sv
  - design/mac_array.sv
  - design/requant_writer.sv
  - design/conv_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/conv_tb.sv

/* tests/conv_tb.sv */
`default_nettype none

module conv_tb import conv_pkg::*;;

	localparam int IMG_SIZE = 6;
	localparam int FRAC_BITS = 5;
	localparam int NPIX = IMG_SIZE * IMG_SIZE;
	localparam int NTESTS = 6;
	localparam int LIMIT = 4 * NTESTS * NPIX * 10;
	localparam logic [1:0] KIND_RAMP = 2'd0;
	localparam logic [1:0] KIND_CONST = 2'd1;
	localparam logic [1:0] KIND_RANDOM = 2'd2;

	// cb_span of zero keeps the fixed codebook, indices and bias
	typedef struct packed {
		codebook_t  codebook;
		tap_idx_t   tap_idx;
		psum_t      bias;
		logic [1:0] kind;
		pixel_t     fill;
		int         cb_span;
	} test_row_t;

	logic      clk;
	logic      rst;
	logic      start;
	codebook_t codebook;
	tap_idx_t  tap_idx;
	psum_t     bias;
	img_req_t  img_req;
	pixel_t    img_rdata;
	out_req_t  out_req;
	logic      finish;

	test_row_t         tests [NTESTS];
	pixel_t            img_mem [NPIX];
	pixel_t            out_mem [NPIX];
	logic              written [NPIX];
	int                write_count;
	int                errors;
	int                checks;
	int                cycles;
	integer            seed;
	logic              rd_hit;
	logic [ADDR_W-1:0] rd_addr;

	tb_clock #(.PERIOD(10), .RST_CYCLES(2)) u_clock (.clk(clk), .rst(rst));

	conv_top #(
		.IMG_SIZE (IMG_SIZE),
		.FRAC_BITS(FRAC_BITS)
	) u_conv_top (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.codebook (codebook),
		.tap_idx  (tap_idx),
		.bias     (bias),
		.img_req  (img_req),
		.img_rdata(img_rdata),
		.out_req  (out_req),
		.finish   (finish)
	);

	// image memory, data arrives the cycle after the request
	always @(posedge clk) begin
		rd_hit = img_req.cs;
		rd_addr = img_req.addr;
		#1;
		if (rd_hit) begin
			if (rd_addr >= NPIX) begin
				$display("image read at address %0d is outside the image", rd_addr);
				errors++;
			end else begin
				img_rdata = img_mem[rd_addr];
			end
		end
	end

	always @(posedge clk) begin
		if (out_req.we) begin
			if (out_req.addr >= NPIX) begin
				$display("output write at address %0d is outside the image", out_req.addr);
				errors++;
			end else begin
				if (written[out_req.addr]) begin
					$display("output address %0d written twice", out_req.addr);
					errors++;
				end
				written[out_req.addr] = 1'b1;
				out_mem[out_req.addr] = out_req.wdata;
			end
			write_count++;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("timeout after %0d cycles, the run never finished", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic check_value(input string name, input int got, input int exp);
		checks++;
		if (got !== exp) begin
			$display("Error: time %0t %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	// zero padded 3x3 sum, bias, 16-bit wrap, shift and clamp
	function automatic int expected_pixel(input int r, input int c);
		int acc;
		int rr;
		int cc;
		int px;
		psum_t wrapped;
		int shifted;
		acc = 0;
		for (int t = 0; t < 9; t++) begin
			rr = r + t / 3 - 1;
			cc = c + t % 3 - 1;
			px = 0;
			if (rr >= 0 && rr < IMG_SIZE && cc >= 0 && cc < IMG_SIZE) begin
				px = img_mem[rr * IMG_SIZE + cc];
			end
			acc += px * int'(codebook[tap_idx[t]]);
		end
		wrapped = psum_t'(acc + int'(bias));
		shifted = int'(wrapped) >>> FRAC_BITS;
		if (shifted > 127) begin
			return 127;
		end
		if (shifted < -128) begin
			return -128;
		end
		return shifted;
	endfunction

	task automatic load_row(input test_row_t row);
		codebook_t cb;
		cb = row.codebook;
		if (row.cb_span != 0) begin
			for (int k = 0; k < 4; k++) begin
				cb[k] = pixel_t'($random(seed) % row.cb_span);
			end
		end
		for (int a = 0; a < NPIX; a++) begin
			case (row.kind)
				KIND_RAMP:  img_mem[a] = pixel_t'(a * 5 - 90);
				KIND_CONST: img_mem[a] = row.fill;
				default:    img_mem[a] = pixel_t'($random(seed));
			endcase
			written[a] = 1'b0;
		end
		write_count = 0;
		@(posedge clk);
		#1;
		codebook = cb;
		tap_idx = row.tap_idx;
		bias = row.bias;
		if (row.cb_span != 0) begin
			tap_idx = tap_idx_t'($random(seed));
			bias = psum_t'($random(seed) % 512);
		end
		start = 1'b1;
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	task automatic run_row(input int n);
		int errs_before;
		errs_before = errors;
		load_row(tests[n]);
		@(negedge clk);
		check_value("finish after start", finish, 0);
		while (!finish) begin
			@(negedge clk);
		end
		check_value("write_count at finish", write_count, NPIX);
		repeat (3) @(negedge clk);
		check_value("write_count after finish", write_count, NPIX);
		for (int a = 0; a < NPIX; a++) begin
			if (!written[a]) begin
				$display("output address %0d was never written", a);
				errors++;
			end else begin
				check_value($sformatf("out_mem[%0d]", a), out_mem[a],
					expected_pixel(a / IMG_SIZE, a % IMG_SIZE));
			end
		end
		$display("test %0d kind %0d: %0d errors", n, tests[n].kind, errors - errs_before);
	endtask

	initial begin
		start = 1'b0;
		codebook = '0;
		tap_idx = '0;
		bias = '0;
		img_rdata = '0;
		errors = 0;
		checks = 0;
		cycles = 0;
		seed = 32'h9518d775;
		// identity, border padding, both saturations, then random codebooks
		tests[0] = '{32'h0000_2000, 18'h00100, 16'sd0, KIND_RAMP, 8'sd0, 0};
		tests[1] = '{32'h0000_0020, 18'h00000, 16'sd0, KIND_CONST, 8'sd1, 0};
		tests[2] = '{32'h0000_007f, 18'h00000, 16'sh4000, KIND_CONST, 8'sd5, 0};
		tests[3] = '{32'h0000_0080, 18'h00000, 16'sd0, KIND_CONST, 8'sd25, 0};
		tests[4] = '{32'h0, 18'h0, 16'sd0, KIND_RANDOM, 8'sd0, 16};
		tests[5] = '{32'h0, 18'h0, 16'sd0, KIND_RANDOM, 8'sd0, 128};
		wait (rst === 1'b1);
		for (int n = 0; n < NTESTS; n++) begin
			run_row(n);
		end
		$display("%0d tests, %0d checks, %0d errors", NTESTS, checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 10,
	parameter int RST_CYCLES = 2
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// active low, released just after an edge
	initial begin
		rst = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#1 rst = 1'b1;
	end

endmodule

`default_nettype wire

/* design/conv_top.sv */
`default_nettype none

module conv_top import conv_pkg::*; #(
	parameter int IMG_SIZE = 8,
	parameter int FRAC_BITS = 5
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      start,
	input  codebook_t codebook,
	input  tap_idx_t  tap_idx,
	input  psum_t     bias,
	output img_req_t  img_req,
	input  pixel_t    img_rdata,
	output out_req_t  out_req,
	output logic      finish
);

	localparam int CW = $clog2(IMG_SIZE);

	logic          pixel_go;
	logic [CW-1:0] row;
	logic [CW-1:0] col;
	window_t       window;
	logic          window_valid;
	window_t       weights;
	psum_t         sum;
	logic          sum_valid;
	logic          last_write;

	conv_ctrl #(
		.IMG_SIZE(IMG_SIZE)
	) u_ctrl (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.window_valid(window_valid),
		.last_write  (last_write),
		.pixel_go    (pixel_go),
		.row         (row),
		.col         (col),
		.finish      (finish)
	);

	window_loader #(
		.IMG_SIZE(IMG_SIZE)
	) u_loader (
		.clk         (clk),
		.rst         (rst),
		.pixel_go    (pixel_go),
		.row         (row),
		.col         (col),
		.img_req     (img_req),
		.img_rdata   (img_rdata),
		.window      (window),
		.window_valid(window_valid)
	);

	weight_decoder u_decoder (
		.clk     (clk),
		.rst     (rst),
		.start   (start),
		.codebook(codebook),
		.tap_idx (tap_idx),
		.weights (weights)
	);

	mac_array u_mac (
		.clk         (clk),
		.rst         (rst),
		.window      (window),
		.window_valid(window_valid),
		.weights     (weights),
		.sum         (sum),
		.sum_valid   (sum_valid)
	);

	requant_writer #(
		.IMG_SIZE (IMG_SIZE),
		.FRAC_BITS(FRAC_BITS)
	) u_writer (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.bias      (bias),
		.sum       (sum),
		.sum_valid (sum_valid),
		.out_req   (out_req),
		.last_write(last_write)
	);

endmodule

`default_nettype wire

/* design/requant_writer.sv */
`default_nettype none

module requant_writer import conv_pkg::*; #(
	parameter int IMG_SIZE = 8,
	parameter int FRAC_BITS = 5
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     start,
	input  psum_t    bias,
	input  psum_t    sum,
	input  logic     sum_valid,
	output out_req_t out_req,
	output logic     last_write
);

	localparam int NPIX = IMG_SIZE * IMG_SIZE;

	psum_t             bias_q;
	psum_t             biased;
	psum_t             shifted;
	pixel_t            clamped;
	logic [ADDR_W-1:0] wr_cnt;
	logic [ADDR_W-1:0] addr_q;
	logic              we_q;
	pixel_t            wdata_q;

	assign biased  = sum + bias_q;
	assign shifted = biased >>> FRAC_BITS;

	// saturate to int8
	always_comb begin
		if (shifted > psum_t'(127)) begin
			clamped = 8'sd127;
		end else if (shifted < psum_t'(-128)) begin
			clamped = -8'sd128;
		end else begin
			clamped = pixel_t'(shifted);
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			bias_q <= bias;
		end
		if (sum_valid) begin
			addr_q  <= wr_cnt;
			wdata_q <= clamped;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			we_q       <= 1'b0;
			last_write <= 1'b0;
			wr_cnt     <= '0;
		end else begin
			we_q       <= sum_valid;
			last_write <= sum_valid && (wr_cnt == ADDR_W'(NPIX - 1));
			if (start) begin
				wr_cnt <= '0;
			end else if (sum_valid) begin
				wr_cnt <= wr_cnt + 1'b1;
			end
		end
	end

	assign out_req = '{addr: addr_q, we: we_q, wdata: wdata_q};

	// writes stay inside the image
	a_addr_range: assert property (@(posedge clk) disable iff (!rst)
		out_req.we |-> (out_req.addr < ADDR_W'(NPIX)));

endmodule

`default_nettype wire

/* design/mac_array.sv */
`default_nettype none

module mac_array import conv_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  window_t window,
	input  logic    window_valid,
	input  window_t weights,
	output psum_t   sum,
	output logic    sum_valid
);

	psum_t [8:0] prod;
	psum_t [3:0] lvl1;
	psum_t [1:0] lvl2;
	psum_t       tree;
	logic        prod_valid;

	// adder tree over the registered products, tap 8 joins last
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			lvl1[i] = prod[2*i] + prod[2*i+1];
		end
		lvl2[0] = lvl1[0] + lvl1[1];
		lvl2[1] = lvl1[2] + lvl1[3];
		tree    = lvl2[0] + lvl2[1] + prod[8];
	end

	always_ff @(posedge clk) begin
		for (int t = 0; t < 9; t++) begin
			prod[t] <= psum_t'(window[t]) * psum_t'(weights[t]);
		end
		sum <= tree;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			prod_valid <= 1'b0;
			sum_valid  <= 1'b0;
		end else begin
			prod_valid <= window_valid;
			sum_valid  <= prod_valid;
		end
	end

endmodule

`default_nettype wire

/* design/weight_decoder.sv */
`default_nettype none

module weight_decoder import conv_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      start,
	input  codebook_t codebook,
	input  tap_idx_t  tap_idx,
	output window_t   weights
);

	codebook_t cb_q;
	tap_idx_t  idx_q;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cb_q  <= '0;
			idx_q <= '0;
		end else if (start) begin
			cb_q  <= codebook;
			idx_q <= tap_idx;
		end
	end

	// each tap picks its codebook entry
	always_comb begin
		for (int t = 0; t < 9; t++) begin
			weights[t] = cb_q[idx_q[t]];
		end
	end

endmodule

`default_nettype wire

/* design/window_loader.sv */
`default_nettype none

module window_loader import conv_pkg::*; #(
	parameter int IMG_SIZE = 8,
	localparam int CW = $clog2(IMG_SIZE)
) (
	input  logic          clk,
	input  logic          rst,
	input  logic          pixel_go,
	input  logic [CW-1:0] row,
	input  logic [CW-1:0] col,
	output img_req_t      img_req,
	input  pixel_t        img_rdata,
	output window_t       window,
	output logic          window_valid
);

	localparam logic [CW-1:0] LAST = CW'(IMG_SIZE - 1);

	logic [CW-1:0]     row_q;
	logic [CW-1:0]     col_q;
	logic              busy;
	logic [1:0]        tap_row;
	logic [1:0]        tap_col;
	logic              last_step;
	logic              in_bounds;
	logic [ADDR_W-1:0] rd_addr;
	logic              rd_pend;
	logic [3:0]        rd_slot;
	logic              last_pend;

	assign last_step = (tap_row == 2'd2) && (tap_col == 2'd2);

	// padding rows above and below the image are skipped
	assign in_bounds = !((row_q == '0) && (tap_row == 2'd0)) &&
		!((row_q == LAST) && (tap_row == 2'd2));

	assign rd_addr = (ADDR_W'(row_q) + ADDR_W'(tap_row) - 1'b1) * ADDR_W'(IMG_SIZE) +
		ADDR_W'(col_q) + ADDR_W'(tap_col) - 1'b1;
	assign img_req = '{addr: rd_addr, cs: busy && in_bounds};

	// walks the window rows of each column still to be fetched
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			row_q   <= '0;
			col_q   <= '0;
			busy    <= 1'b0;
			tap_row <= 2'd0;
			tap_col <= 2'd0;
		end else if (pixel_go) begin
			row_q   <= row;
			col_q   <= col;
			busy    <= (col != LAST);
			tap_row <= 2'd0;
			tap_col <= (col == '0) ? 2'd1 : 2'd2;
		end else if (busy) begin
			if (tap_row == 2'd2) begin
				tap_row <= 2'd0;
				tap_col <= tap_col + 2'd1;
				busy    <= !last_step;
			end else begin
				tap_row <= tap_row + 2'd1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			rd_pend      <= 1'b0;
			last_pend    <= 1'b0;
			window_valid <= 1'b0;
		end else begin
			rd_pend      <= img_req.cs;
			last_pend    <= busy && last_step;
			// right edge needs no reads
			window_valid <= last_pend || (pixel_go && (col == LAST));
		end
	end

	always_ff @(posedge clk) begin
		rd_slot <= 4'(tap_row * 3 + tap_col);
	end

	always_ff @(posedge clk) begin
		if (pixel_go) begin
			if (col == '0) begin
				window <= '0;
			end else begin
				// keep two columns and clear the right one
				for (int r = 0; r < 3; r++) begin
					window[3*r]   <= window[3*r+1];
					window[3*r+1] <= window[3*r+2];
					window[3*r+2] <= '0;
				end
			end
		end else if (rd_pend) begin
			window[rd_slot] <= img_rdata;
		end
	end

	// a new pixel only arrives once the loader has gone idle
	a_no_idle_read: assert property (@(posedge clk) disable iff (!rst)
		pixel_go |-> !img_req.cs && !rd_pend);

endmodule

`default_nettype wire

/* design/conv_ctrl.sv */
`default_nettype none

module conv_ctrl #(
	parameter int IMG_SIZE = 8,
	localparam int CW = $clog2(IMG_SIZE)
) (
	input  logic          clk,
	input  logic          rst,
	input  logic          start,
	input  logic          window_valid,
	input  logic          last_write,
	output logic          pixel_go,
	output logic [CW-1:0] row,
	output logic [CW-1:0] col,
	output logic          finish
);

	localparam logic [CW-1:0] LAST = CW'(IMG_SIZE - 1);

	typedef enum logic {IDLE, RUN} state_t;

	state_t state;
	logic   last_pixel;

	assign last_pixel = (row == LAST) && (col == LAST);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= IDLE;
		end else if (start) begin
			state <= RUN;
		end else if (last_write) begin
			state <= IDLE;
		end
	end

	// raster walk, one step per finished window
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			row <= '0;
			col <= '0;
		end else if (start) begin
			row <= '0;
			col <= '0;
		end else if (window_valid && !last_pixel) begin
			if (col == LAST) begin
				col <= '0;
				row <= row + 1'b1;
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pixel_go <= 1'b0;
			finish   <= 1'b0;
		end else begin
			pixel_go <= start || ((state == RUN) && window_valid && !last_pixel);
			if (start) begin
				finish <= 1'b0;
			end else if (last_write) begin
				finish <= 1'b1;
			end
		end
	end

	// a new run only once the previous one has written its last pixel
	a_no_restart: assert property (@(posedge clk) disable iff (!rst)
		start |-> (state == IDLE));

endmodule

`default_nettype wire

/* design/conv_pkg.sv */
`default_nettype none

package conv_pkg;

	// both memories share one address width
	localparam int ADDR_W = 16;

	typedef logic signed [7:0] pixel_t;

	// products and sums wrap at 16 bits
	typedef logic signed [15:0] psum_t;

	// tap 0 is top-left, row-major
	typedef pixel_t [8:0] window_t;

	typedef pixel_t [3:0] codebook_t;

	// one 2-bit codebook index per tap
	typedef logic [8:0][1:0] tap_idx_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic              cs;
	} img_req_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic              we;
		pixel_t            wdata;
	} out_req_t;

endpackage

`default_nettype wire
